// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int WORD_W = 14;
  localparam int CS_W   = 4;

  // chip-select codes
  localparam logic [CS_W-1:0] CS_NONE = 4'd0;
  localparam logic [CS_W-1:0] CS_VECT = 4'd1;
  localparam logic [CS_W-1:0] CS_ROM  = 4'd2;
  localparam logic [CS_W-1:0] CS_IO   = 4'd4;

  // address map
  localparam logic [ADDR_W-1:0] ROM_BASE  = 32'hffff_0000;
  localparam logic [ADDR_W-1:0] VECT_BASE = 32'hffff_ffe0;
  localparam logic [ADDR_W-1:0] IO_BASE   = 32'h0080_0800;
  localparam logic [ADDR_W-1:0] IO_LAST   = 32'h0080_0fff;

  // i/o register offsets, word index inside the 2 KB window
  localparam int IO_IDX_W = 9;
  localparam logic [IO_IDX_W-1:0] IO_SW  = 9'd0;
  localparam logic [IO_IDX_W-1:0] IO_LED = 9'd1;
  localparam logic [IO_IDX_W-1:0] IO_IRQ = 9'd2;

  // board i/o widths
  localparam int SW_W  = 16;
  localparam int LED_W = 18;
  localparam int IRQ_W = 3;

  // on-chip memory depths in words
  localparam int ROM_DEPTH  = 32;
  localparam int VECT_DEPTH = 8;

  // one bus address, seen whole or split into page / word / byte
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [15:0]       page;
      logic [WORD_W-1:0] word;
      logic [1:0]        byte_off;
    } fields;
  } bus_addr_u;

endpackage

`default_nettype wire

// File: src/dev_bus_if.sv
`default_nettype none

interface dev_bus_if;
  import soc_pkg::*;

  // request side, from the fabric
  logic              stb;
  logic              we;
  logic [3:0]        sel;
  logic [WORD_W-1:0] word;
  logic [DATA_W-1:0] wdata;

  // response side, from the target
  logic [DATA_W-1:0] rdata;
  logic              ack;

  modport fabric (
    output stb, we, sel, word, wdata,
    input  rdata, ack
  );

  modport target (
    input  stb, we, sel, word, wdata,
    output rdata, ack
  );

endinterface

`default_nettype wire

// File: src/addr_decoder.sv
`default_nettype none

module addr_decoder (
  input  soc_pkg::bus_addr_u     adr_i,
  input  logic                   cyc_i,
  output logic [soc_pkg::CS_W-1:0] cs_o
);
  import soc_pkg::*;

  logic in_vect;
  logic in_rom;
  logic in_io;

  // vector window is the top 8 words
  assign in_vect = (adr_i.raw >= VECT_BASE);

  // rom window runs up to just below the vectors
  assign in_rom = (adr_i.raw >= ROM_BASE) && !in_vect;

  assign in_io = (adr_i.raw >= IO_BASE) && (adr_i.raw <= IO_LAST);

  always_comb begin
    cs_o = CS_NONE;
    if (cyc_i) begin
      // vectors checked first, they sit inside the rom page
      if (in_vect) begin
        cs_o = CS_VECT;
      end else if (in_rom) begin
        cs_o = CS_ROM;
      end else if (in_io) begin
        cs_o = CS_IO;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/onchip_mem.sv
`default_nettype none

module onchip_mem #(
  parameter int DEPTH    = 32,
  parameter int WRITABLE = 0
) (
  input  logic sysclock,
  input  logic rst_n,
  dev_bus_if.target bus
);
  import soc_pkg::*;

  logic [DATA_W-1:0]          mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   idx;
  logic [1:0]                 ack_sr;

  // word index wraps at the memory depth
  assign idx = bus.word[$clog2(DEPTH)-1:0];

  // stage 0 marks the first wait cycle, stage 1 is the ack
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ack_sr <= 2'b00;
    end else if (bus.stb) begin
      ack_sr <= {ack_sr[0], ~|ack_sr};
    end else begin
      ack_sr <= 2'b00;
    end
  end

  assign bus.ack = ack_sr[1];

  // read data lands with the ack
  always_ff @(posedge sysclock) begin
    if (bus.stb && ack_sr[0]) begin
      bus.rdata <= mem[idx];
    end
  end

  if (WRITABLE != 0) begin : g_ram
    always_ff @(posedge sysclock) begin
      if (bus.stb && bus.we && ack_sr[0]) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.sel[b]) begin
            mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end else begin : g_rom
    initial begin
      $readmemh("src/monitor.hex", mem);
    end
  end

endmodule

`default_nettype wire

// File: src/io_regs.sv
`default_nettype none

module io_regs (
  input  logic                       sysclock,
  input  logic                       rst_n,
  dev_bus_if.target                  bus,
  input  logic [soc_pkg::SW_W-1:0]   sw_i,
  input  logic                       key_i,
  output logic [soc_pkg::LED_W-1:0]  led_o,
  output logic [soc_pkg::IRQ_W-1:0]  irq_o
);
  import soc_pkg::*;

  logic [SW_W-1:0]     sw_s1;
  logic [SW_W-1:0]     sw_s2;
  logic [SW_W-1:0]     sw_s3;
  logic [2:0]          key_s;
  logic                key_rise;
  logic                sw_change;
  logic [1:0]          pend;
  logic [1:0]          pend_clr;
  logic                ack_q;
  logic                wr_en;
  logic [IO_IDX_W-1:0] io_idx;

  // two-flop synchronisers, third stage for edge detection
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      sw_s1 <= '0;
      sw_s2 <= '0;
      sw_s3 <= '0;
      key_s <= 3'b000;
    end else begin
      sw_s1 <= sw_i;
      sw_s2 <= sw_s1;
      sw_s3 <= sw_s2;
      key_s <= {key_s[1:0], key_i};
    end
  end

  assign key_rise  = key_s[1] & ~key_s[2];
  assign sw_change = (sw_s2 != sw_s3);

  assign io_idx = bus.word[IO_IDX_W-1:0];
  assign wr_en  = bus.stb && bus.we && !ack_q;

  // write-one-to-clear on the irq word
  assign pend_clr = (wr_en && io_idx == IO_IRQ) ? bus.wdata[1:0] : 2'b00;

  // single ack pulse, one wait cycle
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      led_o <= '0;
      pend  <= 2'b00;
    end else begin
      ack_q <= bus.stb && !ack_q;
      // a new event wins over a clear in the same cycle
      pend  <= (pend & ~pend_clr) | {sw_change, key_rise};
      if (wr_en && io_idx == IO_LED) begin
        if (bus.sel[0]) led_o[7:0]   <= bus.wdata[7:0];
        if (bus.sel[1]) led_o[15:8]  <= bus.wdata[15:8];
        if (bus.sel[2]) led_o[17:16] <= bus.wdata[17:16];
      end
    end
  end

  assign bus.ack = ack_q;

  always_ff @(posedge sysclock) begin
    if (bus.stb && !ack_q) begin
      case (io_idx)
        IO_SW:   bus.rdata <= {{(DATA_W-SW_W){1'b0}}, sw_s2};
        IO_LED:  bus.rdata <= {{(DATA_W-LED_W){1'b0}}, led_o};
        IO_IRQ:  bus.rdata <= {{(DATA_W-2){1'b0}}, pend};
        default: bus.rdata <= '0;
      endcase
    end
  end

  // request line: valid flag on top of the pending bits
  assign irq_o = (|pend) ? {1'b1, pend} : 3'b000;

endmodule

`default_nettype wire

// File: src/bus_fabric.sv
`default_nettype none

module bus_fabric (
  input  logic                       sysclock,
  input  logic                       rst_n,
  input  logic                       cyc_i,
  input  logic                       we_i,
  input  logic [3:0]                 sel_i,
  input  soc_pkg::bus_addr_u         adr_i,
  input  logic [soc_pkg::DATA_W-1:0] dat_i,
  input  logic [soc_pkg::CS_W-1:0]   cs_i,
  output logic [soc_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic                       err_o,
  dev_bus_if.fabric                  vect,
  dev_bus_if.fabric                  rom,
  dev_bus_if.fabric                  io
);
  import soc_pkg::*;

  logic [DATA_W-1:0] rdata_sel;
  logic              ack_sel;
  logic              err_q;

  // strobes, one per target
  assign vect.stb = cyc_i && (cs_i == CS_VECT);
  assign rom.stb  = cyc_i && (cs_i == CS_ROM);
  assign io.stb   = cyc_i && (cs_i == CS_IO);

  // the rest of the request is shared
  assign vect.we    = we_i;
  assign vect.sel   = sel_i;
  assign vect.word  = adr_i.fields.word;
  assign vect.wdata = dat_i;
  assign rom.we     = we_i;
  assign rom.sel    = sel_i;
  assign rom.word   = adr_i.fields.word;
  assign rom.wdata  = dat_i;
  assign io.we      = we_i;
  assign io.sel     = sel_i;
  assign io.word    = adr_i.fields.word;
  assign io.wdata   = dat_i;

  always_comb begin
    case (cs_i)
      CS_VECT: begin
        rdata_sel = vect.rdata;
        ack_sel   = vect.ack;
      end
      CS_ROM: begin
        rdata_sel = rom.rdata;
        ack_sel   = rom.ack;
      end
      CS_IO: begin
        rdata_sel = io.rdata;
        ack_sel   = io.ack;
      end
      default: begin
        rdata_sel = '0;
        ack_sel   = 1'b0;
      end
    endcase
  end

  assign ack_o = cyc_i && ack_sel;
  assign dat_o = ack_o ? rdata_sel : '0;

  // unmapped cycle, error one edge after cyc rises
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= cyc_i && (cs_i == CS_NONE) && !err_q;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

// File: src/soc_bus_top.sv
`default_nettype none

module soc_bus_top (
  input  logic                        sysclock,
  input  logic                        rst_n,
  input  logic                        cyc_i,
  input  logic                        we_i,
  input  logic [soc_pkg::ADDR_W-1:0]  adr_i,
  input  logic [3:0]                  sel_i,
  input  logic [soc_pkg::DATA_W-1:0]  dat_i,
  output logic [soc_pkg::DATA_W-1:0]  dat_o,
  output logic                        ack_o,
  output logic                        err_o,
  input  logic [soc_pkg::SW_W-1:0]    sw_i,
  input  logic                        key_i,
  output logic [soc_pkg::LED_W-1:0]   led_o,
  output logic [soc_pkg::IRQ_W-1:0]   irq_o
);
  import soc_pkg::*;

  logic [CS_W-1:0] chipselect;

  dev_bus_if vect_bus ();
  dev_bus_if rom_bus ();
  dev_bus_if io_bus ();

  addr_decoder u_dec (
    .adr_i (adr_i),
    .cyc_i (cyc_i),
    .cs_o  (chipselect)
  );

  bus_fabric u_fabric (
    .sysclock (sysclock),
    .rst_n    (rst_n),
    .cyc_i    (cyc_i),
    .we_i     (we_i),
    .sel_i    (sel_i),
    .adr_i    (adr_i),
    .dat_i    (dat_i),
    .cs_i     (chipselect),
    .dat_o    (dat_o),
    .ack_o    (ack_o),
    .err_o    (err_o),
    .vect     (vect_bus.fabric),
    .rom      (rom_bus.fabric),
    .io       (io_bus.fabric)
  );

  // 0xffffffe0 - 0xffffffff
  onchip_mem #(.DEPTH(VECT_DEPTH), .WRITABLE(1)) u_vect (
    .sysclock (sysclock),
    .rst_n    (rst_n),
    .bus      (vect_bus.target)
  );

  // 0xffff0000 - 0xffffffdf
  onchip_mem #(.DEPTH(ROM_DEPTH), .WRITABLE(0)) u_rom (
    .sysclock (sysclock),
    .rst_n    (rst_n),
    .bus      (rom_bus.target)
  );

  // 0x00800800 - 0x00800fff
  io_regs u_io (
    .sysclock (sysclock),
    .rst_n    (rst_n),
    .bus      (io_bus.target),
    .sw_i     (sw_i),
    .key_i    (key_i),
    .led_o    (led_o),
    .irq_o    (irq_o)
  );

endmodule

`default_nettype wire

// File: test/tb_soc.sv
`default_nettype none

module tb_soc;
  import soc_pkg::*;

  logic              sysclock;
  logic              rst_n;
  logic              cyc_i;
  logic              we_i;
  logic [ADDR_W-1:0] adr_i;
  logic [3:0]        sel_i;
  logic [DATA_W-1:0] dat_i;
  logic [DATA_W-1:0] dat_o;
  logic              ack_o;
  logic              err_o;
  logic [SW_W-1:0]   sw_i;
  logic              key_i;
  logic [LED_W-1:0]  led_o;
  logic [IRQ_W-1:0]  irq_o;

  // reference model state
  logic [DATA_W-1:0] rom_m [ROM_DEPTH];
  logic [DATA_W-1:0] vect_m [VECT_DEPTH];
  bit                vect_ok [VECT_DEPTH];
  logic [LED_W-1:0]  led_m;
  logic [1:0]        pend_m;

  integer seed;
  int     checks;
  int     errors;
  int     checks0;
  int     errors0;

  soc_bus_top dut_i (
    .sysclock (sysclock),
    .rst_n    (rst_n),
    .cyc_i    (cyc_i),
    .we_i     (we_i),
    .adr_i    (adr_i),
    .sel_i    (sel_i),
    .dat_i    (dat_i),
    .dat_o    (dat_o),
    .ack_o    (ack_o),
    .err_o    (err_o),
    .sw_i     (sw_i),
    .key_i    (key_i),
    .led_o    (led_o),
    .irq_o    (irq_o)
  );

  always #5 sysclock = ~sysclock;

  function automatic logic [IRQ_W-1:0] irq_of(input logic [1:0] p);
    return (p != 2'b00) ? {1'b1, p} : 3'b000;
  endfunction

  function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
      input logic [DATA_W-1:0] wr, input logic [3:0] sel);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = wr[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] io_exp(input logic [IO_IDX_W-1:0] idx);
    case (idx)
      IO_SW:   return {16'b0, sw_i};
      IO_LED:  return {14'b0, led_m};
      IO_IRQ:  return {30'b0, pend_m};
      default: return '0;
    endcase
  endfunction

  // word aligned and below the vector window
  function automatic logic [ADDR_W-1:0] rand_rom_addr();
    logic [15:0] off;
    off = $random(seed);
    off[1:0] = 2'b00;
    if (off >= 16'hffe0) off = off - 16'h0100;
    return ROM_BASE | {16'b0, off};
  endfunction

  function automatic logic [ADDR_W-1:0] rand_unmapped();
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 100; i++) begin
      a = $random(seed);
      a[1:0] = 2'b00;
      if (a < ROM_BASE && !(a >= IO_BASE && a <= IO_LAST)) return a;
    end
    return 32'h0000_0000;
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
      input string what);
    checks++;
    if (got !== exp) report($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_resp(input logic got_ack, input logic got_err, input logic exp_err,
      input string what);
    checks++;
    if (got_ack !== !exp_err || got_err !== exp_err) begin
      report($sformatf("%s: ended with ack=%b err=%b, expected %s", what, got_ack, got_err,
        exp_err ? "err" : "ack"));
    end
  endtask

  task automatic check_irq(input logic [IRQ_W-1:0] got, input logic [IRQ_W-1:0] exp,
      input string what);
    checks++;
    if (got !== exp) report($sformatf("%s: irq %b, expected %b", what, got, exp));
  endtask

  task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp,
      input string what);
    checks++;
    if (got !== exp) report($sformatf("%s: led %h, expected %h", what, got, exp));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge sysclock);
      #1;
    end
  endtask

  // one transfer and then one idle cycle with cyc low
  task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] adr,
      input logic [3:0] sel, input logic [DATA_W-1:0] dat,
      output logic [DATA_W-1:0] rdata, output logic got_ack, output logic got_err);
    int n;
    n = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdata = '0;
    cyc_i = 1'b1;
    we_i = we;
    adr_i = adr;
    sel_i = sel;
    dat_i = dat;
    while (!got_ack && !got_err && n < 20) begin
      @(negedge sysclock);
      got_ack = ack_o;
      got_err = err_o;
      rdata = dat_o;
      n++;
    end
    if (!got_ack && !got_err) begin
      errors++;
      $display("transfer to %h never completed within 20 cycles", adr);
    end
    @(posedge sysclock);
    #1;
    cyc_i = 1'b0;
    we_i = 1'b0;
    idle(1);
  endtask

  task automatic wait_irq(input string what);
    int n;
    n = 0;
    while (irq_o !== irq_of(pend_m) && n < 20) begin
      idle(1);
      n++;
    end
    checks++;
    if (irq_o !== irq_of(pend_m)) begin
      errors++;
      $display("%s: irq_o did not reach %b within 20 cycles", what, irq_of(pend_m));
    end
  endtask

  task automatic rom_read(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] q;
    logic ack;
    logic err;
    bus_xfer(1'b0, a, 4'hf, '0, q, ack, err);
    check_resp(ack, err, 1'b0, "rom read");
    check_data(q, rom_m[a[6:2]], $sformatf("rom read %h", a));
  endtask

  task automatic vect_write(input logic [2:0] k, input logic [DATA_W-1:0] d,
      input logic [3:0] sel);
    logic [DATA_W-1:0] q;
    logic [3:0] s;
    logic ack;
    logic err;
    // first write of a word fills it completely
    s = vect_ok[k] ? sel : 4'hf;
    bus_xfer(1'b1, VECT_BASE + {k, 2'b00}, s, d, q, ack, err);
    check_resp(ack, err, 1'b0, "vector write");
    vect_m[k] = merge(vect_m[k], d, s);
    vect_ok[k] = 1'b1;
  endtask

  task automatic vect_read(input logic [2:0] k);
    logic [DATA_W-1:0] q;
    logic ack;
    logic err;
    bus_xfer(1'b0, VECT_BASE + {k, 2'b00}, 4'hf, '0, q, ack, err);
    check_resp(ack, err, 1'b0, "vector read");
    check_data(q, vect_m[k], $sformatf("vector word %0d", k));
  endtask

  task automatic io_read(input logic [IO_IDX_W-1:0] idx);
    logic [DATA_W-1:0] q;
    logic ack;
    logic err;
    bus_xfer(1'b0, IO_BASE + {idx, 2'b00}, 4'hf, '0, q, ack, err);
    check_resp(ack, err, 1'b0, "io read");
    check_data(q, io_exp(idx), $sformatf("io word %0d", idx));
  endtask

  task automatic led_write(input logic [DATA_W-1:0] d, input logic [3:0] sel);
    logic [DATA_W-1:0] q;
    logic ack;
    logic err;
    bus_xfer(1'b1, IO_BASE + {IO_LED, 2'b00}, sel, d, q, ack, err);
    check_resp(ack, err, 1'b0, "led write");
    if (sel[0]) led_m[7:0] = d[7:0];
    if (sel[1]) led_m[15:8] = d[15:8];
    if (sel[2]) led_m[17:16] = d[17:16];
    check_led(led_o, led_m, "led after write");
  endtask

  task automatic irq_clear(input logic [1:0] mask);
    logic [DATA_W-1:0] q;
    logic ack;
    logic err;
    bus_xfer(1'b1, IO_BASE + {IO_IRQ, 2'b00}, 4'hf, {30'b0, mask}, q, ack, err);
    check_resp(ack, err, 1'b0, "irq clear");
    pend_m = pend_m & ~mask;
    check_irq(irq_o, irq_of(pend_m), "irq after clear");
  endtask

  task automatic unmapped_access();
    logic [DATA_W-1:0] q;
    logic [ADDR_W-1:0] a;
    logic ack;
    logic err;
    a = rand_unmapped();
    bus_xfer(a[2], a, 4'hf, a, q, ack, err);
    check_resp(ack, err, 1'b1, $sformatf("unmapped %h", a));
    check_data(q, '0, "data on bus error");
  endtask

  task automatic key_press();
    key_i = 1'b1;
    pend_m[0] = 1'b1;
    wait_irq("key edge");
    key_i = 1'b0;
    idle(3);
  endtask

  task automatic switch_change();
    logic [SW_W-1:0] v;
    v = $random(seed);
    if (v == sw_i) v = ~v;
    sw_i = v;
    pend_m[1] = 1'b1;
    idle(3);
    wait_irq("switch change");
  endtask

  task automatic start_test();
    checks0 = checks;
    errors0 = errors;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - checks0, errors - errors0);
  endtask

  initial begin
    logic [31:0] r;
    logic [DATA_W-1:0] d;
    seed = 32'h2fa7_d83b;
    sysclock = 1'b0;
    rst_n = 1'b0;
    cyc_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    sel_i = 4'h0;
    dat_i = '0;
    sw_i = '0;
    key_i = 1'b0;
    checks = 0;
    errors = 0;
    led_m = '0;
    pend_m = 2'b00;
    for (int k = 0; k < VECT_DEPTH; k++) vect_ok[k] = 1'b0;
    $readmemh("src/monitor.hex", rom_m);
    repeat (8) @(posedge sysclock);
    #1;
    rst_n = 1'b1;
    idle(2);
    check_led(led_o, '0, "led after reset");
    check_irq(irq_o, '0, "irq after reset");

    start_test();
    // last rom word below the vectors and then random addresses
    rom_read(32'hffff_ffdc);
    for (int i = 0; i < 40; i++) rom_read(rand_rom_addr());
    end_test("rom reads");

    start_test();
    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      d = $random(seed);
      vect_write(r[2:0], d, r[7:4]);
      if (vect_ok[r[10:8]]) vect_read(r[10:8]);
    end
    end_test("vector ram");

    start_test();
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      d = $random(seed);
      led_write(d, r[3:0]);
      io_read(IO_LED);
    end
    for (int i = 0; i < 4; i++) begin
      switch_change();
      io_read(IO_SW);
    end
    end_test("leds and switches");

    start_test();
    for (int i = 0; i < 20; i++) unmapped_access();
    end_test("unmapped");

    start_test();
    irq_clear(2'b11);
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      if (r[0]) key_press();
      else switch_change();
      if (r[1]) key_press();
      io_read(IO_IRQ);
      irq_clear(r[5:4]);
    end
    end_test("interrupts");

    start_test();
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      d = $random(seed);
      case (r[2:0])
        3'd0: rom_read(rand_rom_addr());
        3'd1: led_write(d, r[7:4]);
        3'd2: vect_write(r[10:8], d, r[7:4]);
        3'd3: begin
          if (vect_ok[r[10:8]]) vect_read(r[10:8]);
          else vect_write(r[10:8], d, 4'hf);
        end
        3'd4: io_read({6'b0, r[13:11]});
        3'd5: irq_clear(d[1:0]);
        3'd6: rom_read(rand_rom_addr());
        default: unmapped_access();
      endcase
    end
    end_test("mixed sequence");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/soc_pkg.sv
src/dev_bus_if.sv
src/addr_decoder.sv
src/onchip_mem.sv
src/io_regs.sv
src/bus_fabric.sv
src/soc_bus_top.sv
test/tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - src/soc_pkg.sv
  - src/dev_bus_if.sv
  - src/addr_decoder.sv
  - src/onchip_mem.sv
  - src/io_regs.sv
  - src/bus_fabric.sv
  - src/soc_bus_top.sv
  - target: test
    files:
      - test/tb_soc.sv

// File: src/monitor.hex
// one 32-bit word per line, word 0 first: {index, ~index, index ^ 5a, 80 + index}
00ff5a80
01fe5b81
02fd5882
03fc5983
04fb5e84
05fa5f85
06f95c86
07f85d87
08f75288
09f65389
0af5508a
0bf4518b
0cf3568c
0df2578d
0ef1548e
0ff0558f
10ef4a90
11ee4b91
12ed4892
13ec4993
14eb4e94
15ea4f95
16e94c96
17e84d97
18e74298
19e64399
1ae5409a
1be4419b
1ce3469c
1de2479d
1ee1449e
1fe0459f
